/* Bender.yml */
package:
  name: saber_tracker

sources:
  - files:
      - common/video_pkg.sv
      - common/tracker_pkg.sv
      - source/mask_stage.sv
      - tracker/bounding_box.sv
      - tracker/divider.sv
      - tracker/center_of_mass.sv
      - source/overlay_renderer.sv
      - source/saber_tracker_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/saber_tracker_checker.sv
      - test/saber_tracker_tb.sv

/* common/tracker_pkg.sv */
`default_nettype none

package tracker_pkg;
  import video_pkg::*;

  typedef logic [2:0]  chan_sel_t;  // which color feeds the shirt mask
  typedef logic [31:0] sum_t;       // coordinate sum or pixel count

  // any code not listed here picks zero
  localparam chan_sel_t CHAN_GREEN = 3'd0;
  localparam chan_sel_t CHAN_RED   = 3'd1;
  localparam chan_sel_t CHAN_BLUE  = 3'd2;

  // inclusive extent of the shirt mask
  typedef struct packed {
    hcount_t x_min;
    vcount_t y_min;
    hcount_t x_max;
    vcount_t y_max;
  } box_t;

  // everything the tracker reports per frame
  typedef struct packed {
    box_t    box;
    hcount_t saber_x;  // saber centroid
    vcount_t saber_y;
  } location_t;

endpackage

`default_nettype wire

/* common/video_pkg.sv */
`default_nettype none

package video_pkg;

  typedef logic [10:0] hcount_t;    // horizontal pixel position
  typedef logic [9:0]  vcount_t;    // vertical pixel position
  typedef logic [15:0] pixel565_t;  // raw camera pixel, r5 g6 b5
  typedef logic [7:0]  channel_t;   // one color or intensity value

  // full color pixel after expansion
  typedef struct packed {
    channel_t red;
    channel_t green;
    channel_t blue;
  } rgb_t;

  // raster timing that travels with every pixel
  typedef struct packed {
    hcount_t hcount;
    vcount_t vcount;
    logic    hsync;
    logic    vsync;
    logic    active;     // inside the visible area
    logic    new_frame;  // one cycle at hcount == 0 and vcount == 0
  } video_timing_t;

endpackage

`default_nettype wire

/* project.f */
common/video_pkg.sv
common/tracker_pkg.sv
source/mask_stage.sv
tracker/bounding_box.sv
tracker/divider.sv
tracker/center_of_mass.sv
source/overlay_renderer.sv
source/saber_tracker_top.sv
test/tb_clock_gen.sv
test/saber_tracker_checker.sv
test/saber_tracker_tb.sv

/* source/mask_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mask_stage
  import video_pkg::*;
  import tracker_pkg::*;
#(
  parameter channel_t SABER_LO = 8'd14,  // fixed blue window for the saber
  parameter channel_t SABER_HI = 8'd32
) (
  input  wire           clk_pixel,
  input  wire           sys_rst,
  input  wire video_timing_t timing_in,
  input  wire pixel565_t     pixel_in,
  input  wire chan_sel_t     chan_sel,
  input  wire channel_t      lower_bound,
  input  wire channel_t      upper_bound,
  output video_timing_t timing,      // timing_in delayed by 2
  output rgb_t          rgb,         // expanded pixel delayed by 2
  output logic          mask_shirt,
  output logic          mask_saber
);

  rgb_t          rgb_exp;    // 5-6-5 moved to the top of each byte
  channel_t      sel_exp;    // channel picked by chan_sel
  rgb_t          rgb_s1;
  channel_t      sel_s1;
  channel_t      lo_s1;      // bounds ride along with the pixel
  channel_t      hi_s1;
  video_timing_t timing_s1;

  always_comb begin
    rgb_exp.red   = {pixel_in[15:11], 3'b000};
    rgb_exp.green = {pixel_in[10:5], 2'b00};
    rgb_exp.blue  = {pixel_in[4:0], 3'b000};
    case (chan_sel)
      CHAN_GREEN: sel_exp = rgb_exp.green;
      CHAN_RED:   sel_exp = rgb_exp.red;
      CHAN_BLUE:  sel_exp = rgb_exp.blue;
      default:    sel_exp = '0;  // no luma/chroma here
    endcase
  end

  // stage 1 expands and selects, stage 2 compares
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      timing_s1  <= '0;
      timing     <= '0;
      mask_shirt <= 1'b0;
      mask_saber <= 1'b0;
    end else begin
      timing_s1  <= timing_in;
      timing     <= timing_s1;
      mask_shirt <= timing_s1.active && (sel_s1 >= lo_s1) && (sel_s1 <= hi_s1);
      mask_saber <= timing_s1.active && (rgb_s1.blue >= SABER_LO)
                    && (rgb_s1.blue <= SABER_HI);  // inclusive on both ends
    end
  end

  always_ff @(posedge clk_pixel) begin
    rgb_s1 <= rgb_exp;
    sel_s1 <= sel_exp;
    lo_s1  <= lower_bound;
    hi_s1  <= upper_bound;
    rgb    <= rgb_s1;  // keep color aligned with the masks
  end

endmodule

`default_nettype wire

/* source/overlay_renderer.sv */
`timescale 1ns/1ps
`default_nettype none

module overlay_renderer
  import video_pkg::*;
  import tracker_pkg::*;
(
  input  wire           clk_pixel,
  input  wire           sys_rst,
  input  wire video_timing_t timing,
  input  wire rgb_t     rgb,
  input  wire box_t     box,
  input  wire           box_valid,
  input  wire hcount_t  saber_x,
  input  wire vcount_t  saber_y,
  input  wire           com_valid,
  output rgb_t          pixel_out,
  output video_timing_t timing_out
);

  box_t    box_r;     // last published box
  logic    box_on;    // hidden until the first box_valid
  hcount_t cross_x;
  vcount_t cross_y;
  logic    cross_on;
  logic    on_cross;
  logic    in_box;
  rgb_t    pix_next;

  always_comb begin
    on_cross = cross_on && (timing.hcount == cross_x || timing.vcount == cross_y);
    in_box   = box_on
               && timing.hcount >= box_r.x_min && timing.hcount <= box_r.x_max
               && timing.vcount >= box_r.y_min && timing.vcount <= box_r.y_max;
    if (!timing.active) pix_next = '0;  // blanking stays black
    else if (on_cross) pix_next = '{red: 8'hF2, green: 8'hF2, blue: 8'hF2};
    else if (in_box) pix_next = '{red: 8'hFF, green: 8'hFF, blue: 8'hFF};
    else pix_next = rgb;
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      box_on     <= 1'b0;
      cross_on   <= 1'b0;
      pixel_out  <= '0;
      timing_out <= '0;
    end else begin
      pixel_out  <= pix_next;
      timing_out <= timing;
      if (box_valid) box_on <= 1'b1;
      if (com_valid) cross_on <= 1'b1;
    end
  end

  // overlay only moves on a strobe, so at most once a frame
  always_ff @(posedge clk_pixel) begin
    if (box_valid) box_r <= box;
    if (com_valid) begin
      cross_x <= saber_x;
      cross_y <= saber_y;
    end
  end

endmodule

`default_nettype wire

/* source/saber_tracker_top.sv */
`timescale 1ns/1ps
`default_nettype none

module saber_tracker_top
  import video_pkg::*;
  import tracker_pkg::*;
#(
  parameter channel_t SABER_LO = 8'd14,
  parameter channel_t SABER_HI = 8'd32,
  parameter int       DIV_W    = 32
) (
  input  wire           clk_pixel,
  input  wire           sys_rst,
  input  wire video_timing_t timing_in,
  input  wire pixel565_t     pixel_in,
  input  wire chan_sel_t     chan_sel,
  input  wire channel_t      lower_bound,
  input  wire channel_t      upper_bound,
  output rgb_t          pixel_out,
  output video_timing_t timing_out,
  output location_t     location,
  output logic          box_valid,
  output logic          com_valid
);

  video_timing_t timing_m;  // timing aligned with the masks
  rgb_t          rgb_m;
  logic          mask_shirt;
  logic          mask_saber;
  box_t          box;
  hcount_t       saber_x;
  vcount_t       saber_y;

  assign location = '{box: box, saber_x: saber_x, saber_y: saber_y};

  mask_stage #(.SABER_LO(SABER_LO), .SABER_HI(SABER_HI)) mask_i (
    .clk_pixel, .sys_rst, .timing_in, .pixel_in, .chan_sel, .lower_bound, .upper_bound,
    .timing(timing_m), .rgb(rgb_m), .mask_shirt, .mask_saber
  );

  bounding_box box_i (
    .clk_pixel, .sys_rst, .timing(timing_m), .mask(mask_shirt), .box, .box_valid
  );

  center_of_mass #(.DIV_W(DIV_W)) com_i (
    .clk_pixel, .sys_rst, .timing(timing_m), .mask(mask_saber),
    .saber_x, .saber_y, .com_valid
  );

  overlay_renderer overlay_i (
    .clk_pixel, .sys_rst, .timing(timing_m), .rgb(rgb_m), .box, .box_valid,
    .saber_x, .saber_y, .com_valid, .pixel_out, .timing_out
  );

endmodule

`default_nettype wire

/* test/saber_tracker_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module saber_tracker_checker
  import video_pkg::*;
(
  input wire                clk_pixel,
  input wire                sys_rst,
  input wire video_timing_t timing_in,
  input wire video_timing_t timing_out,
  input wire rgb_t          pixel_out,
  input wire                box_valid,
  input wire                com_valid
);

  int unsigned fail_count = 0;  // failed assertions so far

  // strobes are single cycle pulses
  box_strobe_single: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    box_valid |=> !box_valid)
    else begin
      fail_count++;
      $error("box_valid high on two cycles in a row");
    end

  com_strobe_single: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    com_valid |=> !com_valid)
    else begin
      fail_count++;
      $error("com_valid high on two cycles in a row");
    end

  // mask stage 2 cycles plus overlay 1 cycle
  timing_latency: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    timing_out == $past(timing_in, 3))
    else begin
      fail_count++;
      $error("timing_out is not timing_in delayed by 3 cycles");
    end

  blank_is_black: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    !timing_out.active |-> pixel_out == '0)
    else begin
      fail_count++;
      $error("pixel_out not zero outside active video");
    end

endmodule

`default_nettype wire

/* test/saber_tracker_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module saber_tracker_tb
  import video_pkg::*;
  import tracker_pkg::*;
();

  localparam int H_ACTIVE  = 24;
  localparam int H_TOTAL   = 32;  // 8 cycles of horizontal blanking
  localparam int V_ACTIVE  = 16;
  localparam int V_TOTAL   = 20;
  localparam int FRAME_LEN = H_TOTAL * V_TOTAL;

  // one trace line with the scene and what the tracker should report for it
  typedef struct packed {
    chan_sel_t chan;
    channel_t  lo;
    channel_t  hi;
    pixel565_t bg;
    box_t      shirt;      // empty when x_min > x_max
    pixel565_t shirt_pix;
    box_t      saber;      // drawn on top of the shirt
    pixel565_t saber_pix;
    logic      box_valid;
    box_t      box;
    logic      com_valid;
    hcount_t   com_x;
    vcount_t   com_y;
  } frame_t;

  // what was driven on one cycle
  typedef struct packed {
    video_timing_t timing;
    pixel565_t     pixel;
  } drive_t;

  logic          clk_pixel;
  logic          sys_rst;
  video_timing_t timing_in;
  pixel565_t     pixel_in;
  chan_sel_t     chan_sel;
  channel_t      lower_bound;
  channel_t      upper_bound;
  rgb_t          pixel_out;
  video_timing_t timing_out;
  location_t     location;
  logic          box_valid;
  logic          com_valid;

  frame_t  frames [$];
  drive_t  hist [4];         // hist[3] is the input 3 cycles back
  logic    raster_started;
  box_t    held_box;         // location the DUT should be holding
  hcount_t held_x;
  vcount_t held_y;
  logic    pend_box;         // overlay picks up a strobe one cycle later
  logic    pend_com;
  box_t    model_box;
  logic    model_box_on;
  hcount_t model_cross_x;
  vcount_t model_cross_y;
  logic    model_cross_on;
  int      w;

  tb_clock_gen clock_i (.clk_pixel(clk_pixel), .sys_rst(sys_rst));

  saber_tracker_top #(.SABER_LO(8'd14), .SABER_HI(8'd32), .DIV_W(32)) dut_i (
    .clk_pixel(clk_pixel), .sys_rst(sys_rst), .timing_in(timing_in), .pixel_in(pixel_in),
    .chan_sel(chan_sel), .lower_bound(lower_bound), .upper_bound(upper_bound),
    .pixel_out(pixel_out), .timing_out(timing_out), .location(location),
    .box_valid(box_valid), .com_valid(com_valid)
  );

  bind saber_tracker_top saber_tracker_checker checker_i (
    .clk_pixel(clk_pixel), .sys_rst(sys_rst), .timing_in(timing_in),
    .timing_out(timing_out), .pixel_out(pixel_out), .box_valid(box_valid),
    .com_valid(com_valid)
  );

  task automatic stop_with_failure(string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_rgb(string name, rgb_t got, rgb_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("ERROR t=%0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_box(string name, box_t got, box_t exp);
    if (got !== exp)
      stop_with_failure($sformatf(
        "ERROR t=%0t %s got (%0d,%0d,%0d,%0d) expected (%0d,%0d,%0d,%0d)",
        $time, name, got.x_min, got.y_min, got.x_max, got.y_max,
        exp.x_min, exp.y_min, exp.x_max, exp.y_max));
  endtask

  task automatic check_saber(hcount_t got_x, vcount_t got_y, hcount_t exp_x, vcount_t exp_y);
    if (got_x !== exp_x || got_y !== exp_y)
      stop_with_failure($sformatf(
        "ERROR t=%0t location.saber_x/y got (%0d,%0d) expected (%0d,%0d)",
        $time, got_x, got_y, exp_x, exp_y));
  endtask

  function automatic box_t make_box(int x0, int y0, int x1, int y1);
    return '{x_min: hcount_t'(x0), y_min: vcount_t'(y0),
             x_max: hcount_t'(x1), y_max: vcount_t'(y1)};
  endfunction

  function automatic logic in_rect(box_t r, hcount_t h, vcount_t v);
    return h >= r.x_min && h <= r.x_max && v >= r.y_min && v <= r.y_max;  // inclusive
  endfunction

  // expected pixel_out from the overlay priority rule
  function automatic rgb_t overlay_model(drive_t d);
    rgb_t cam;
    cam.red   = {d.pixel[15:11], 3'b000};
    cam.green = {d.pixel[10:5], 2'b00};
    cam.blue  = {d.pixel[4:0], 3'b000};
    if (!d.timing.active) return '0;
    if (model_cross_on && (d.timing.hcount == model_cross_x || d.timing.vcount == model_cross_y))
      return {3{8'hF2}};  // crosshair wins
    if (model_box_on && in_rect(model_box, d.timing.hcount, d.timing.vcount)) return {3{8'hFF}};
    return cam;
  endfunction

  task automatic load_trace();
    int    fd;
    int    code;
    int    v [22];
    string line;
    frame_t fr;
    fd = $fopen("test/saber_tracker_trace.txt", "r");
    if (fd == 0) stop_with_failure("cannot open test/saber_tracker_trace.txt");
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0) break;
      if (line.len() < 2 || line[0] == "#") continue;  // blank or column notes
      code = $sscanf(line, "%d %h %h %h %d %d %d %d %h %d %d %d %d %h %d %d %d %d %d %d %d %d",
        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
        v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20], v[21]);
      if (code != 22) stop_with_failure("trace line does not have 22 columns");
      fr.chan      = chan_sel_t'(v[0]);
      fr.lo        = channel_t'(v[1]);
      fr.hi        = channel_t'(v[2]);
      fr.bg        = pixel565_t'(v[3]);
      fr.shirt     = make_box(v[4], v[5], v[6], v[7]);
      fr.shirt_pix = pixel565_t'(v[8]);
      fr.saber     = make_box(v[9], v[10], v[11], v[12]);
      fr.saber_pix = pixel565_t'(v[13]);
      fr.box_valid = v[14] != 0;
      fr.box       = make_box(v[15], v[16], v[17], v[18]);
      fr.com_valid = v[19] != 0;
      fr.com_x     = hcount_t'(v[20]);
      fr.com_y     = vcount_t'(v[21]);
      frames.push_back(fr);
    end
    $fclose(fd);
    if (frames.size() == 0) stop_with_failure("trace holds no frames");
  endtask

  task automatic drive_inputs(drive_t d, frame_t fr);
    timing_in   <= d.timing;
    pixel_in    <= d.pixel;
    chan_sel    <= fr.chan;
    lower_bound <= fr.lo;   // bounds change only with the frame
    upper_bound <= fr.hi;
    hist[3] = hist[2];
    hist[2] = hist[1];
    hist[1] = hist[0];
    hist[0] = d;
  endtask

  task automatic drive_raster();
    frame_t fr;
    drive_t d;
    int     f;
    int     h;
    int     v;
    int     waited;
    waited = 0;
    do begin
      @(posedge clk_pixel);
      waited++;
      if (waited > 20) stop_with_failure("sys_rst was never released");
    end while (sys_rst);
    for (f = 0; f <= frames.size(); f++) begin
      fr = '0;
      fr.lo = 8'hFF;  // the trailing frame matches nothing and only flushes the last report
      if (f < frames.size()) fr = frames[f];
      for (v = 0; v < V_TOTAL; v++) begin
        for (h = 0; h < H_TOTAL; h++) begin
          @(posedge clk_pixel);
          d.timing.hcount    = hcount_t'(h);
          d.timing.vcount    = vcount_t'(v);
          d.timing.hsync     = h >= 26 && h < 29;
          d.timing.vsync     = v >= 17 && v < 19;
          d.timing.active    = h < H_ACTIVE && v < V_ACTIVE;
          d.timing.new_frame = h == 0 && v == 0;
          if (!d.timing.active) d.pixel = fr.saber_pix;  // masks must ignore blanking
          else if (in_rect(fr.saber, d.timing.hcount, d.timing.vcount)) d.pixel = fr.saber_pix;
          else if (in_rect(fr.shirt, d.timing.hcount, d.timing.vcount)) d.pixel = fr.shirt_pix;
          else d.pixel = fr.bg;
          drive_inputs(d, fr);
          if (d.timing.new_frame) raster_started = 1'b1;
        end
      end
    end
    @(posedge clk_pixel);
    drive_inputs('0, fr);  // idle after the last frame
  endtask

  // checks one cycle of outputs on the falling edge
  task automatic next_cycle();
    @(negedge clk_pixel);
    if (dut_i.checker_i.fail_count != 0) stop_with_failure("a checker assertion failed");
    check_rgb("pixel_out", pixel_out, overlay_model(hist[3]));
    if (pend_box) begin
      model_box    = held_box;
      model_box_on = 1'b1;
      pend_box     = 1'b0;
    end
    if (pend_com) begin
      model_cross_x  = held_x;
      model_cross_y  = held_y;
      model_cross_on = 1'b1;
      pend_com       = 1'b0;
    end
  endtask

  // window w spans frame w and carries the reports of frame w-1
  task automatic watch_window(int idx);
    frame_t exp;
    logic   box_seen;
    logic   com_seen;
    int     cyc;
    exp = '0;
    if (idx > 0) exp = frames[idx-1];
    box_seen = 1'b0;
    com_seen = 1'b0;
    for (cyc = 0; cyc < FRAME_LEN; cyc++) begin  // timeout is one frame
      next_cycle();
      if (box_valid) begin
        if (!exp.box_valid || box_seen) stop_with_failure("box_valid arrived where none was due");
        check_box("location.box", location.box, exp.box);
        box_seen = 1'b1;
        held_box = exp.box;
        pend_box = 1'b1;
      end
      if (com_valid) begin
        if (!exp.com_valid || com_seen) stop_with_failure("com_valid arrived where none was due");
        check_saber(location.saber_x, location.saber_y, exp.com_x, exp.com_y);
        com_seen = 1'b1;
        held_x   = exp.com_x;
        held_y   = exp.com_y;
        pend_com = 1'b1;
      end
    end
    if (exp.box_valid && !box_seen) stop_with_failure("box_valid did not arrive within a frame");
    if (exp.com_valid && !com_seen) stop_with_failure("com_valid did not arrive within a frame");
    check_box("location.box", location.box, held_box);  // held between updates
    check_saber(location.saber_x, location.saber_y, held_x, held_y);
  endtask

  task automatic wait_for_raster();
    int waited;
    waited = 0;
    while (!raster_started) begin
      next_cycle();
      waited++;
      if (waited > 40) stop_with_failure("the raster never started");
    end
  endtask

  initial begin
    timing_in      = '0;
    pixel_in       = '0;
    chan_sel       = '0;
    lower_bound    = '0;
    upper_bound    = '0;
    hist[0]        = '0;
    hist[1]        = '0;
    hist[2]        = '0;
    hist[3]        = '0;
    raster_started = 1'b0;
    held_box       = '0;  // reset value of the box and centroid
    held_x         = '0;
    held_y         = '0;
    pend_box       = 1'b0;
    pend_com       = 1'b0;
    model_box      = '0;
    model_box_on   = 1'b0;
    model_cross_x  = '0;
    model_cross_y  = '0;
    model_cross_on = 1'b0;
    load_trace();
    fork
      drive_raster();
    join_none
    wait_for_raster();
    for (w = 0; w <= frames.size(); w++) watch_window(w);
    if (dut_i.checker_i.fail_count == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      stop_with_failure("a checker assertion failed");
    end
  end

endmodule

`default_nettype wire

/* test/saber_tracker_trace.txt */
# chan lo hi bg | shirt x0 y0 x1 y1 pix | saber x0 y0 x1 y1 pix | box_v x_min y_min x_max y_max | com_v x y
# chan and coordinates decimal, bounds and pixels hex, a rectangle with x0 > x1 is empty
# red channel finds the red shirt
1 c0 ff 1081  3 2 10 7 f900  15 9 18 12 0103  1 3 2 10 7  1 16 10
# green channel finds the saber instead of the blue shirt
0 18 28 1081  12 1 20 5 001e  4 11 9 13 0103  1 4 11 9 13  1 6 12
# blue channel finds the bottom row
2 e0 ff 1081  0 15 23 15 001e  22 0 23 2 0103  1 0 15 23 15  1 22 1
# invalid code with lower bound zero takes every pixel, no saber
5 00 00 1081  2 2 5 5 f900  1 1 0 0 0103  1 0 0 23 15  0 0 0
# invalid code with lower bound one takes nothing
7 01 ff 1081  2 2 5 5 f900  7 3 7 8 0103  0 0 0 0 0  1 7 5
# both masks empty
1 c0 ff 1081  1 1 0 0 f900  1 1 0 0 0103  0 0 0 0 0  0 0 0
# saber overlaps the shirt and both pass the green window
0 18 28 1081  5 4 14 9 f900  12 8 16 10 0103  1 5 4 16 10  1 14 9

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 20,  // 40 ns pixel clock
  parameter int RST_CYCLES     = 3
) (
  output logic clk_pixel,
  output logic sys_rst
);

  initial begin
    clk_pixel = 1'b0;
    forever #(HALF_PERIOD_NS) clk_pixel = ~clk_pixel;
  end

  initial begin
    sys_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_pixel);
    sys_rst <= 1'b0;  // released on a clock edge like any other input
  end

endmodule

`default_nettype wire

/* tracker/bounding_box.sv */
`timescale 1ns/1ps
`default_nettype none

module bounding_box
  import video_pkg::*;
  import tracker_pkg::*;
(
  input  wire           clk_pixel,
  input  wire           sys_rst,
  input  wire video_timing_t timing,  // already aligned with mask
  input  wire           mask,
  output box_t          box,
  output logic          box_valid
);

  hcount_t x_lo;
  hcount_t x_hi;
  vcount_t y_lo;
  vcount_t y_hi;
  logic    seen;   // at least one mask pixel this frame
  logic    fresh;  // next mask pixel starts a new extent

  // first pixel of a frame belongs to that frame, so it restarts the trackers
  assign fresh = timing.new_frame || !seen;

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      seen      <= 1'b0;
      box       <= '0;
      box_valid <= 1'b0;
    end else begin
      box_valid <= 1'b0;
      if (timing.new_frame) begin
        box_valid <= seen;  // empty frame gives no strobe
        if (seen) box <= '{x_min: x_lo, y_min: y_lo, x_max: x_hi, y_max: y_hi};
        seen <= mask;
      end else if (mask) begin
        seen <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (mask) begin
      x_lo <= (fresh || timing.hcount < x_lo) ? timing.hcount : x_lo;
      x_hi <= (fresh || timing.hcount > x_hi) ? timing.hcount : x_hi;
      y_lo <= (fresh || timing.vcount < y_lo) ? timing.vcount : y_lo;
      y_hi <= (fresh || timing.vcount > y_hi) ? timing.vcount : y_hi;
    end
  end

endmodule

`default_nettype wire

/* tracker/center_of_mass.sv */
`timescale 1ns/1ps
`default_nettype none

module center_of_mass
  import video_pkg::*;
  import tracker_pkg::*;
#(
  parameter int DIV_W = 32
) (
  input  wire           clk_pixel,
  input  wire           sys_rst,
  input  wire video_timing_t timing,
  input  wire           mask,
  output hcount_t       saber_x,
  output vcount_t       saber_y,
  output logic          com_valid
);

  sum_t x_sum;     // running sums for the current frame
  sum_t y_sum;
  sum_t count;
  sum_t x_snap;    // frame totals handed to the dividers
  sum_t y_snap;
  sum_t cnt_snap;
  logic div_start;
  sum_t x_quot;
  sum_t y_quot;
  logic x_done;
  logic y_done;    // both finish together

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      x_sum     <= '0;
      y_sum     <= '0;
      count     <= '0;
      div_start <= 1'b0;
      saber_x   <= '0;
      saber_y   <= '0;
      com_valid <= 1'b0;
    end else begin
      div_start <= timing.new_frame && (count != '0);  // nothing to divide if empty
      if (timing.new_frame) begin
        // restart with the first pixel of the new frame
        x_sum <= mask ? sum_t'(timing.hcount) : '0;
        y_sum <= mask ? sum_t'(timing.vcount) : '0;
        count <= mask ? sum_t'(1) : '0;
      end else if (mask) begin
        x_sum <= x_sum + sum_t'(timing.hcount);
        y_sum <= y_sum + sum_t'(timing.vcount);
        count <= count + sum_t'(1);
      end
      com_valid <= x_done && y_done;
      if (x_done && y_done) begin
        saber_x <= hcount_t'(x_quot);  // mean fits the raster width
        saber_y <= vcount_t'(y_quot);
      end
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (timing.new_frame) begin
      x_snap   <= x_sum;
      y_snap   <= y_sum;
      cnt_snap <= count;
    end
  end

  divider #(.DIV_W(DIV_W)) div_x_i (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .start     (div_start),
    .dividend  (x_snap),
    .divisor   (cnt_snap),
    .quotient  (x_quot),
    .done      (x_done)
  );

  divider #(.DIV_W(DIV_W)) div_y_i (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .start     (div_start),
    .dividend  (y_snap),
    .divisor   (cnt_snap),
    .quotient  (y_quot),
    .done      (y_done)
  );

endmodule

`default_nettype wire

/* tracker/divider.sv */
`timescale 1ns/1ps
`default_nettype none

module divider
  import tracker_pkg::*;
#(
  parameter int DIV_W = 32  // quotient bits, one per cycle
) (
  input  wire       clk_pixel,
  input  wire       sys_rst,
  input  wire       start,
  input  wire sum_t dividend,
  input  wire sum_t divisor,
  output sum_t      quotient,
  output logic      done
);

  localparam int CNT_W = $clog2(DIV_W + 1);

  logic [DIV_W-1:0] q_r;      // dividend shifts out, quotient shifts in
  logic [DIV_W-1:0] rem_r;
  logic [DIV_W-1:0] div_r;
  logic [CNT_W-1:0] cnt;      // iterations still to go
  logic             busy;
  logic [DIV_W-1:0] src_q;
  logic [DIV_W-1:0] src_rem;
  logic [DIV_W-1:0] src_div;
  logic [DIV_W:0]   rem_shift;
  logic             fits;

  assign busy = (cnt != '0);
  assign quotient = sum_t'(q_r);

  // first iteration runs straight off the inputs in the start cycle
  always_comb begin
    src_q     = start ? DIV_W'(dividend) : q_r;
    src_rem   = start ? '0 : rem_r;
    src_div   = start ? DIV_W'(divisor) : div_r;
    rem_shift = {src_rem, src_q[DIV_W-1]};
    fits      = rem_shift >= {1'b0, src_div};  // restore when it does not fit
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= busy && (cnt == CNT_W'(1));
      if (start) cnt <= CNT_W'(DIV_W - 1);
      else if (busy) cnt <= cnt - CNT_W'(1);
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (start || busy) begin
      div_r <= src_div;
      rem_r <= fits ? DIV_W'(rem_shift - {1'b0, src_div}) : rem_shift[DIV_W-1:0];
      q_r   <= {src_q[DIV_W-2:0], fits};
    end
  end

endmodule

`default_nettype wire
